// ==== rtl/cpu_settings.svh ====
// Width, SPI command and program-counter constants shared by the processor.

`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data and address width.
`define WORD_W 16
`define BYTE_W 8

// operand field of a one-word instruction.
`define OPND_W 10

// every instruction is one word.
`define PC_STEP 2

// serial RAM commands.
`define SPI_CMD_W 8
`define SPI_CMD_READ 3
`define SPI_CMD_WRITE 2

`endif

// ==== rtl/cpu_pkg.sv ====
// Processor types: opcode, source and condition encodings,
// the instruction union, the decoded instruction and memory requests.

`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [`BYTE_W-1:0] byte_t;

  typedef enum logic [3:0] {
    OP_NOP    = 4'h0,
    OP_HALT   = 4'h1,
    OP_TRAP   = 4'h2,
    OP_LOAD   = 4'h3,
    OP_STORE  = 4'h4,
    OP_ADD    = 4'h5,
    OP_SUB    = 4'h6,
    OP_AND    = 4'h7,
    OP_OR     = 4'h8,
    OP_XOR    = 4'h9,
    OP_TEST   = 4'hA,
    OP_BRANCH = 4'hB,
    OP_IF     = 4'hC,
    OP_OUT_LO = 4'hD,
    OP_OUT_HI = 4'hE,
    OP_UNDEF  = 4'hF
  } opcode_e;

  // only immediate and RAM are legal.
  typedef enum logic [1:0] {
    SRC_IMM   = 2'd0,
    SRC_RAM   = 2'd1,
    SRC_RSVD2 = 2'd2,
    SRC_RSVD3 = 2'd3
  } source_e;

  typedef enum logic [1:0] {
    COND_ZERO     = 2'd0,
    COND_NOT_ZERO = 2'd1,
    COND_NEG      = 2'd2,
    COND_NOT_NEG  = 2'd3
  } cond_e;

  ////////////////////////////////////////
  // instruction word, two views.
  ////////////////////////////////////////

  typedef struct packed {
    opcode_e             op;
    source_e             src;
    logic [`OPND_W-1:0]  operand;
  } operand_form_t;

  typedef struct packed {
    opcode_e             op;
    logic [`OPND_W-1:0]  spare;
    cond_e               cond;
  } cond_form_t;

  typedef union packed {
    operand_form_t opnd;
    cond_form_t    cnd;
  } inst_u;

  typedef struct packed {
    opcode_e op;
    logic    uses_ram;
    logic    illegal;
    word_t   operand;
    cond_e   cond;
  } decoded_t;

  typedef struct packed {
    logic  start_read;
    logic  start_write;
    word_t addr;
    word_t wdata;
  } mem_req_t;

endpackage

`default_nettype wire

// ==== rtl/spi_ram_master.sv ====
// Serial RAM master for one-word reads and writes.
// Serves the fetch and execute stages, one transaction at a time.

`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module spi_ram_master (
  input  wire               clk,
  input  wire               rst_n,
  input  wire cpu_pkg::mem_req_t fetch_req,
  input  wire cpu_pkg::mem_req_t exec_req,
  output cpu_pkg::word_t    rd_data,
  output logic              fetch_done,
  output logic              exec_done_mem,
  output logic              spi_clk,
  output logic              spi_select,
  output logic              spi_mosi,
  input  wire               spi_miso
);

  import cpu_pkg::*;

  // command, address and data bits of one transaction.
  localparam int FRAME_W = `SPI_CMD_W + 2 * `WORD_W;
  localparam int TICK_W = $clog2(2 * FRAME_W + 2);
  localparam logic [TICK_W-1:0] SHIFT_END = TICK_W'(2 * FRAME_W);
  localparam logic [`SPI_CMD_W-1:0] CMD_READ = `SPI_CMD_READ;
  localparam logic [`SPI_CMD_W-1:0] CMD_WRITE = `SPI_CMD_WRITE;

  logic               active;
  logic               owner_exec;
  logic [TICK_W-1:0]  tick;
  logic [FRAME_W-1:0] shreg;
  logic               fetch_start;
  logic               exec_start;
  mem_req_t           req;

  assign fetch_start = fetch_req.start_read | fetch_req.start_write;
  assign exec_start = exec_req.start_read | exec_req.start_write;
  assign req = fetch_start ? fetch_req : exec_req;
  assign spi_mosi = active & shreg[FRAME_W-1];

  ////////////////////////////////////////
  // transaction sequencing.
  ////////////////////////////////////////

  // spi_clk rises on even ticks and falls on odd ones.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active <= 1'b0;
      owner_exec <= 1'b0;
      tick <= '0;
      spi_clk <= 1'b0;
      spi_select <= 1'b1;
      fetch_done <= 1'b0;
      exec_done_mem <= 1'b0;
    end else begin
      fetch_done <= 1'b0;
      exec_done_mem <= 1'b0;
      if (!active) begin
        if (fetch_start | exec_start) begin
          active <= 1'b1;
          owner_exec <= !fetch_start;
          tick <= '0;
          spi_select <= 1'b0;
        end
      end else begin
        tick <= tick + 1'b1;
        if (tick < SHIFT_END) begin
          spi_clk <= ~tick[0];
        end else if (tick == SHIFT_END) begin
          spi_select <= 1'b1;
        end else begin
          active <= 1'b0;
          fetch_done <= !owner_exec;
          exec_done_mem <= owner_exec;
        end
      end
    end
  end

  ////////////////////////////////////////
  // shift registers.
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!active && (fetch_start || exec_start)) begin
      shreg <= {req.start_write ? CMD_WRITE : CMD_READ, req.addr, req.wdata};
    end else if (active && tick < SHIFT_END) begin
      if (tick[0]) begin
        shreg <= shreg << 1;
      end else begin
        // sampled as spi_clk rises.
        rd_data <= {rd_data[`WORD_W-2:0], spi_miso};
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
// Step sequencing, program counter and instruction fetch.
// Holds the processor state and the halt and trap reporting.

`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module fetch_stage (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                step,
  output cpu_pkg::mem_req_t  fetch_req,
  input  wire                fetch_done,
  input  wire cpu_pkg::word_t rd_data,
  output cpu_pkg::inst_u     inst_word,
  output logic               inst_valid,
  input  wire                exec_done,
  input  wire                branch_taken,
  input  wire cpu_pkg::word_t branch_offset,
  input  wire                go_halt,
  input  wire                go_trap,
  output logic               busy,
  output logic               halt,
  output logic               trap
);

  import cpu_pkg::*;

  localparam word_t PC_INC = `PC_STEP;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_EXEC,
    ST_HALT,
    ST_TRAP,
    ST_UNTRAP
  } state_e;

  state_e state;
  word_t  pc;
  logic   step_q;
  logic   step_rise;
  logic   issue;

  assign step_rise = step & ~step_q;

  assign fetch_req = '{start_read: issue, start_write: 1'b0, addr: pc, wdata: '0};

  assign busy = (state == ST_FETCH) || (state == ST_EXEC);
  assign halt = state == ST_HALT;
  assign trap = state == ST_TRAP;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      pc <= '0;
      step_q <= 1'b0;
      issue <= 1'b0;
      inst_valid <= 1'b0;
    end else begin
      step_q <= step;
      issue <= 1'b0;
      inst_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (step_rise) begin
            state <= ST_FETCH;
            issue <= 1'b1;
          end
        end
        ST_FETCH: begin
          if (fetch_done) begin
            state <= ST_EXEC;
            inst_valid <= 1'b1;
          end
        end
        ST_EXEC: begin
          if (exec_done) begin
            // branch target is relative to the next instruction.
            pc <= pc + PC_INC + (branch_taken ? branch_offset : '0);
            if (go_halt) begin
              state <= ST_HALT;
            end else if (go_trap) begin
              state <= ST_TRAP;
            end else begin
              state <= ST_IDLE;
            end
          end
        end
        ST_TRAP: begin
          if (step_rise) begin
            state <= ST_UNTRAP;
          end
        end
        ST_UNTRAP: begin
          if (!step) begin
            state <= ST_IDLE;
          end
        end
        ST_HALT: begin
          state <= ST_HALT;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_done) begin
      inst_word <= rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/inst_decoder.sv ====
// Instruction decoder: operand and condition views of the word,
// operand extension and illegal-instruction detection.

`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module inst_decoder (
  input  wire cpu_pkg::inst_u inst_word,
  output cpu_pkg::decoded_t   dec
);

  import cpu_pkg::*;

  opcode_e             op;
  source_e             src;
  logic [`OPND_W-1:0]  raw;
  logic                src_op;

  assign op = inst_word.opnd.op;
  assign src = inst_word.opnd.src;
  assign raw = inst_word.opnd.operand;

  // ops that read or write through the source field.
  assign src_op = op inside {OP_LOAD, OP_STORE, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};

  always_comb begin
    dec.op = op;
    dec.cond = inst_word.cnd.cond;
    dec.uses_ram = src_op && (src == SRC_RAM);
    dec.illegal = (op == OP_UNDEF)
      || (src_op && !(src inside {SRC_IMM, SRC_RAM}))
      || ((op == OP_STORE) && (src == SRC_IMM));
    if (op == OP_BRANCH) begin
      // signed offset.
      dec.operand = {{(`WORD_W - `OPND_W){raw[`OPND_W-1]}}, raw};
    end else begin
      dec.operand = {{(`WORD_W - `OPND_W){1'b0}}, raw};
    end
  end

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
// Execute stage: accumulator, flags, conditional skip, RAM operand
// access, output byte and the end-of-instruction report.

`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module execute_stage (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire cpu_pkg::decoded_t dec,
  input  wire                    inst_valid,
  output cpu_pkg::mem_req_t      exec_req,
  input  wire                    exec_done_mem,
  input  wire cpu_pkg::word_t    rd_data,
  output logic                   exec_done,
  output logic                   branch_taken,
  output cpu_pkg::word_t         branch_offset,
  output logic                   go_halt,
  output logic                   go_trap,
  output cpu_pkg::byte_t         data_out
);

  import cpu_pkg::*;

  typedef enum logic {
    EX_IDLE,
    EX_WAIT
  } ex_state_e;

  ex_state_e state;
  word_t     acc;
  word_t     rhs;
  word_t     alu_res;
  logic      zero;
  logic      neg;
  logic      skip;
  logic      cond_met;
  logic      req_rd;
  logic      req_wr;
  logic      start_mem;
  logic      finish;

  assign exec_req = '{start_read: req_rd, start_write: req_wr, addr: dec.operand, wdata: acc};

  assign rhs = (state == EX_WAIT) ? rd_data : dec.operand;

  assign start_mem = (state == EX_IDLE) && inst_valid && !skip && !dec.illegal && dec.uses_ram;
  assign finish = ((state == EX_IDLE) && inst_valid && !start_mem)
    || ((state == EX_WAIT) && exec_done_mem);

  always_comb begin
    case (dec.op)
      OP_ADD:  alu_res = acc + rhs;
      OP_SUB:  alu_res = acc - rhs;
      OP_AND:  alu_res = acc & rhs;
      OP_OR:   alu_res = acc | rhs;
      OP_XOR:  alu_res = acc ^ rhs;
      default: alu_res = rhs;
    endcase
  end

  always_comb begin
    case (dec.cond)
      COND_ZERO:     cond_met = zero;
      COND_NOT_ZERO: cond_met = !zero;
      COND_NEG:      cond_met = neg;
      default:       cond_met = !neg;
    endcase
  end

  ////////////////////////////////////////
  // instruction completion.
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= EX_IDLE;
      acc <= '0;
      zero <= 1'b0;
      neg <= 1'b0;
      skip <= 1'b0;
      req_rd <= 1'b0;
      req_wr <= 1'b0;
      exec_done <= 1'b0;
      branch_taken <= 1'b0;
      go_halt <= 1'b0;
      go_trap <= 1'b0;
      data_out <= '0;
    end else begin
      exec_done <= finish;
      req_rd <= 1'b0;
      req_wr <= 1'b0;
      if (start_mem) begin
        state <= EX_WAIT;
        req_rd <= dec.op != OP_STORE;
        req_wr <= dec.op == OP_STORE;
      end
      if (finish) begin
        state <= EX_IDLE;
        branch_taken <= 1'b0;
        go_halt <= 1'b0;
        go_trap <= 1'b0;
        skip <= 1'b0;
        // a skipped instruction only advances.
        if (!skip) begin
          if (dec.illegal) begin
            go_trap <= 1'b1;
          end else begin
            case (dec.op)
              OP_HALT: go_halt <= 1'b1;
              OP_TRAP: go_trap <= 1'b1;
              OP_LOAD: acc <= rhs;
              OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                acc <= alu_res;
                zero <= alu_res == '0;
                neg <= alu_res[`WORD_W-1];
              end
              OP_TEST: begin
                zero <= acc == '0;
                neg <= acc[`WORD_W-1];
              end
              OP_BRANCH: branch_taken <= 1'b1;
              OP_IF:     skip <= !cond_met;
              OP_OUT_LO: data_out <= acc[`BYTE_W-1:0];
              OP_OUT_HI: data_out <= acc[`WORD_W-1:`BYTE_W];
              default: ;
            endcase
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (finish) begin
      branch_offset <= dec.operand;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cpu_top.sv ====
// Processor top level: fetch, decode and execute stages
// around the shared serial RAM master.

`timescale 1ns/10ps
`default_nettype none

module cpu_top (
  input  wire                 clk,
  input  wire                 rst_n,
  output logic                spi_mosi,
  output logic                spi_select,
  output logic                spi_clk,
  input  wire                 spi_miso,
  input  wire                 step,
  output logic                busy,
  output logic                halt,
  output logic                trap,
  input  wire cpu_pkg::byte_t data_in,
  output cpu_pkg::byte_t      data_out
);

  import cpu_pkg::*;

  mem_req_t fetch_req;
  mem_req_t exec_req;
  word_t    rd_data;
  logic     fetch_done;
  logic     exec_done_mem;
  inst_u    inst_word;
  logic     inst_valid;
  decoded_t dec;
  logic     exec_done;
  logic     branch_taken;
  word_t    branch_offset;
  logic     go_halt;
  logic     go_trap;

  // data_in stays on the pinout; no instruction reads it here.

  spi_ram_master u_spi_ram_master (
    .clk(clk), .rst_n(rst_n),
    .fetch_req(fetch_req), .exec_req(exec_req), .rd_data(rd_data),
    .fetch_done(fetch_done), .exec_done_mem(exec_done_mem),
    .spi_clk(spi_clk), .spi_select(spi_select), .spi_mosi(spi_mosi), .spi_miso(spi_miso)
  );

  fetch_stage u_fetch_stage (
    .clk(clk), .rst_n(rst_n), .step(step),
    .fetch_req(fetch_req), .fetch_done(fetch_done), .rd_data(rd_data),
    .inst_word(inst_word), .inst_valid(inst_valid),
    .exec_done(exec_done), .branch_taken(branch_taken), .branch_offset(branch_offset),
    .go_halt(go_halt), .go_trap(go_trap),
    .busy(busy), .halt(halt), .trap(trap)
  );

  inst_decoder u_inst_decoder (
    .inst_word(inst_word),
    .dec(dec)
  );

  execute_stage u_execute_stage (
    .clk(clk), .rst_n(rst_n), .dec(dec), .inst_valid(inst_valid),
    .exec_req(exec_req), .exec_done_mem(exec_done_mem), .rd_data(rd_data),
    .exec_done(exec_done), .branch_taken(branch_taken), .branch_offset(branch_offset),
    .go_halt(go_halt), .go_trap(go_trap), .data_out(data_out)
  );

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
// Testbench clock generator, 4 ns period.

`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic clk
);

  // half period in ns.
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== tb/spi_ram_model.sv ====
// Behavioral serial RAM, mode 0, byte addressed, high byte first.
// Backdoor tasks for random fill, word preload and word peek.

`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module spi_ram_model (
  input  wire  spi_clk,
  input  wire  spi_select,
  input  wire  spi_mosi,
  output logic spi_miso
);

  import cpu_pkg::*;

  localparam int HDR_BITS = `SPI_CMD_W + `WORD_W;
  localparam int FRAME_BITS = HDR_BITS + `WORD_W;
  localparam logic [`SPI_CMD_W-1:0] CMD_WRITE = `SPI_CMD_W'(`SPI_CMD_WRITE);

  byte_t                 mem [0:(1 << `WORD_W)-1];
  logic [FRAME_BITS-1:0] shin;
  logic [FRAME_BITS-1:0] frame_next;
  int                    nbits = 0;
  word_t                 rd_word;
  word_t                 out_sr;
  logic                  miso_q = 1'b0;

  assign frame_next = {shin[FRAME_BITS-2:0], spi_mosi};
  assign spi_miso = miso_q;

  ////////////////////////////////////////
  // command, address and write data in.
  ////////////////////////////////////////

  always @(posedge spi_clk or posedge spi_select) begin
    if (spi_select) begin
      nbits <= 0;
    end else begin
      shin <= frame_next;
      nbits <= nbits + 1;
      // address complete, fetch the word for a read.
      if (nbits == HDR_BITS - 1) begin
        rd_word <= {mem[frame_next[`WORD_W-1:0]], mem[frame_next[`WORD_W-1:0] + 16'd1]};
      end
      if (nbits == FRAME_BITS - 1 && frame_next[FRAME_BITS-1 -: `SPI_CMD_W] == CMD_WRITE) begin
        mem[frame_next[2*`WORD_W-1:`WORD_W]] = frame_next[`WORD_W-1:`BYTE_W];
        mem[frame_next[2*`WORD_W-1:`WORD_W] + 16'd1] = frame_next[`BYTE_W-1:0];
      end
    end
  end

  // read data changes on the falling edge.
  always @(negedge spi_clk) begin
    if (!spi_select) begin
      if (nbits == HDR_BITS) begin
        miso_q <= rd_word[`WORD_W-1];
        out_sr <= rd_word << 1;
      end else if (nbits > HDR_BITS && nbits < FRAME_BITS) begin
        miso_q <= out_sr[`WORD_W-1];
        out_sr <= out_sr << 1;
      end
    end
  end

  task automatic fill_random();
    for (int i = 0; i < (1 << `WORD_W); i++) begin
      mem[16'(i)] = byte_t'($urandom);
    end
  endtask

  task automatic preload(input word_t addr, input word_t data);
    mem[addr] = data[`WORD_W-1:`BYTE_W];
    mem[addr + 16'd1] = data[`BYTE_W-1:0];
  endtask

  task automatic peek(input word_t addr, output word_t data);
    data = {mem[addr], mem[addr + 16'd1]};
  endtask

endmodule

`default_nettype wire

// ==== tb/tb_cpu.sv ====
// Processor testbench: program table, step loop and compare tasks.
// Each row loads a program, steps it and checks data_out and status.

`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module tb_cpu;

  import cpu_pkg::*;

  localparam int ROWS = 6;
  localparam int PROG_LEN = 8;
  localparam int MAX_STEPS = 10;
  localparam int RISE_LIMIT = 8;
  localparam int FALL_LIMIT = 400;
  // status as {halt, trap}.
  localparam logic [1:0] RUN = 2'b00;
  localparam logic [1:0] HALTED = 2'b10;
  localparam logic [1:0] TRAPPED = 2'b01;

  wire   clk;
  wire   spi_miso;
  logic  rst_n;
  logic  step;
  byte_t data_in;
  byte_t data_out;
  logic  busy;
  logic  halt;
  logic  trap;
  logic  spi_clk;
  logic  spi_select;
  logic  spi_mosi;

  word_t      prog [ROWS][PROG_LEN];
  byte_t      exp_out [ROWS][MAX_STEPS];
  logic [1:0] exp_st [ROWS][MAX_STEPS];
  int         n_steps [ROWS];
  logic       has_peek [ROWS];
  word_t      peek_addr [ROWS];
  word_t      peek_val [ROWS];
  int         cur_row;
  int         cur_step;
  int         row_errors;
  int         rows_failed;

  tb_clock clock_gen (.clk(clk));

  cpu_top dut (
    .clk(clk), .rst_n(rst_n), .spi_mosi(spi_mosi), .spi_select(spi_select),
    .spi_clk(spi_clk), .spi_miso(spi_miso), .step(step), .busy(busy),
    .halt(halt), .trap(trap), .data_in(data_in), .data_out(data_out)
  );

  spi_ram_model ram_model (
    .spi_clk(spi_clk), .spi_select(spi_select), .spi_mosi(spi_mosi), .spi_miso(spi_miso)
  );

  ////////////////////////////////////////
  // instruction encoding.
  ////////////////////////////////////////

  // op in 15:12, source in 11:10, operand in 9:0.
  function automatic word_t encode(opcode_e op, logic [1:0] src, logic [9:0] val);
    return {op, src, val};
  endfunction

  function automatic word_t immediate(opcode_e op, logic [9:0] val);
    return encode(op, 2'd0, val);
  endfunction

  function automatic word_t direct(opcode_e op, logic [9:0] addr);
    return encode(op, 2'd1, addr);
  endfunction

  // condition sits in the low two bits.
  function automatic word_t if_cond(cond_e c);
    return encode(OP_IF, 2'd0, {8'd0, c});
  endfunction

  function automatic word_t plain(opcode_e op);
    return encode(op, 2'd0, 10'd0);
  endfunction

  task automatic build_table();
    has_peek = '{default: 1'b0};
    // wraparound arithmetic on immediates.
    prog[0] = '{immediate(OP_LOAD, 10'h155), immediate(OP_SUB, 10'h2AA), plain(OP_OUT_HI),
                immediate(OP_XOR, 10'h0F0), immediate(OP_AND, 10'h3C7),
                immediate(OP_OR, 10'h300), immediate(OP_ADD, 10'h3FF), plain(OP_OUT_LO)};
    exp_out[0] = '{8'h00, 8'h00, 8'hFE, 8'hFE, 8'hFE, 8'hFE, 8'hFE, 8'h42, 8'h00, 8'h00};
    exp_st[0] = '{default: RUN};
    n_steps[0] = 8;
    // store, then read back through the RAM operand path.
    prog[1] = '{immediate(OP_LOAD, 10'h1C3), direct(OP_STORE, 10'h200),
                immediate(OP_ADD, 10'h07D), direct(OP_ADD, 10'h200), plain(OP_OUT_LO),
                direct(OP_LOAD, 10'h200), plain(OP_OUT_LO), plain(OP_HALT)};
    exp_out[1] = '{8'h00, 8'h00, 8'h00, 8'h00, 8'h03, 8'h03, 8'hC3, 8'hC3, 8'hC3, 8'h00};
    exp_st[1] = '{RUN, RUN, RUN, RUN, RUN, RUN, RUN, HALTED, HALTED, RUN};
    n_steps[1] = 9;
    has_peek[1] = 1'b1;
    peek_addr[1] = 16'h0200;
    peek_val[1] = 16'h01C3;
    prog[2] = '{immediate(OP_SUB, 10'h001), if_cond(COND_NOT_NEG), plain(OP_OUT_LO),
                if_cond(COND_NEG), plain(OP_OUT_HI), immediate(OP_AND, 10'h000),
                if_cond(COND_NOT_ZERO), plain(OP_OUT_LO)};
    exp_out[2] = '{8'h00, 8'h00, 8'h00, 8'h00, 8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'h00, 8'h00};
    exp_st[2] = '{default: RUN};
    n_steps[2] = 8;
    // load keeps the old flags until test.
    prog[3] = '{immediate(OP_SUB, 10'h000), immediate(OP_LOAD, 10'h005), if_cond(COND_ZERO),
                plain(OP_OUT_LO), plain(OP_TEST), if_cond(COND_ZERO), plain(OP_OUT_HI),
                plain(OP_HALT)};
    exp_out[3] = '{8'h00, 8'h00, 8'h00, 8'h05, 8'h05, 8'h05, 8'h05, 8'h05, 8'h00, 8'h00};
    exp_st[3] = '{RUN, RUN, RUN, RUN, RUN, RUN, RUN, HALTED, RUN, RUN};
    n_steps[3] = 8;
    // undefined op and store immediate trap; a step clears each.
    prog[4] = '{immediate(OP_LOAD, 10'h012), plain(OP_UNDEF), plain(OP_OUT_LO),
                immediate(OP_STORE, 10'h300), immediate(OP_AND, 10'h000),
                if_cond(COND_ZERO), plain(OP_OUT_HI), plain(OP_HALT)};
    exp_out[4] = '{8'h00, 8'h00, 8'h00, 8'h12, 8'h12, 8'h12, 8'h12, 8'h12, 8'h00, 8'h00};
    exp_st[4] = '{RUN, TRAPPED, RUN, RUN, TRAPPED, RUN, RUN, RUN, RUN, HALTED};
    n_steps[4] = 10;
    // target is pc + 2 + offset, backward offset is -6.
    prog[5] = '{immediate(OP_LOAD, 10'h001), immediate(OP_BRANCH, 10'h002),
                immediate(OP_LOAD, 10'h3AA), immediate(OP_ADD, 10'h001), plain(OP_OUT_LO),
                immediate(OP_ADD, 10'h010), immediate(OP_BRANCH, 10'h3FA), plain(OP_NOP)};
    exp_out[5] = '{8'h00, 8'h00, 8'h00, 8'h02, 8'h02, 8'h02, 8'h12, 8'h12, 8'h12, 8'h22};
    exp_st[5] = '{default: RUN};
    n_steps[5] = 10;
  endtask

  ////////////////////////////////////////
  // compare tasks.
  ////////////////////////////////////////

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h (row %0d step %0d)",
               name, got, exp, cur_row, cur_step);
      row_errors++;
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h (row %0d)", name, got, exp, cur_row);
      row_errors++;
    end
  endtask

  task automatic check_status(input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("Fail {halt,trap}: got %h expected %h (row %0d step %0d)",
               got, exp, cur_row, cur_step);
      row_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h (row %0d)", name, got, exp, cur_row);
      row_errors++;
    end
  endtask

  ////////////////////////////////////////
  // stimulus.
  ////////////////////////////////////////

  task automatic apply_reset();
    @(negedge clk);
    rst_n = 1'b0;
    step = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
  endtask

  // press, wait for the instruction to finish, release.
  task automatic press_step(input logic [1:0] prior, output logic ok);
    int n;
    ok = 1'b1;
    @(negedge clk);
    step = 1'b1;
    n = 0;
    while (!busy && n < RISE_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (busy) begin
      n = 0;
      while (busy && n < FALL_LIMIT) begin
        @(negedge clk);
        n++;
      end
      if (busy) begin
        $display("row %0d step %0d: busy stayed high, instruction never finished",
                 cur_row, cur_step);
        ok = 1'b0;
      end
    end else if (prior == RUN) begin
      $display("row %0d step %0d: step did not start an instruction", cur_row, cur_step);
      ok = 1'b0;
    end
    step = 1'b0;
  endtask

  task automatic run_row();
    logic       ok;
    logic [1:0] prior;
    word_t      peeked;
    prior = RUN;
    row_errors = 0;
    cur_step = 0;
    apply_reset();
    check_status({halt, trap}, RUN);
    check_byte("data_out", data_out, 8'h00);
    check_bit("busy", busy, 1'b0);
    check_bit("spi_clk", spi_clk, 1'b0);
    check_bit("spi_select", spi_select, 1'b1);
    ram_model.fill_random();
    for (int i = 0; i < PROG_LEN; i++) begin
      ram_model.preload(word_t'(i * `PC_STEP), prog[cur_row][i]);
    end
    for (cur_step = 0; cur_step < n_steps[cur_row]; cur_step++) begin
      press_step(prior, ok);
      if (!ok) begin
        row_errors++;
        break;
      end
      check_byte("data_out", data_out, exp_out[cur_row][cur_step]);
      check_status({halt, trap}, exp_st[cur_row][cur_step]);
      prior = exp_st[cur_row][cur_step];
    end
    if (has_peek[cur_row]) begin
      ram_model.peek(peek_addr[cur_row], peeked);
      check_word("ram word", peeked, peek_val[cur_row]);
    end
  endtask

  initial begin
    void'($urandom(96010));
    rst_n = 1'b0;
    step = 1'b0;
    data_in = '0;
    rows_failed = 0;
    build_table();
    for (cur_row = 0; cur_row < ROWS; cur_row++) begin
      run_row();
      if (row_errors == 0) begin
        $display("row %0d: ok", cur_row);
      end else begin
        $display("row %0d: failed with %0d errors", cur_row, row_errors);
        rows_failed++;
      end
    end
    $display("rows run %0d, passed %0d, failed %0d", ROWS, ROWS - rows_failed, rows_failed);
    if (rows_failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+rtl
rtl/cpu_pkg.sv
rtl/spi_ram_master.sv
rtl/fetch_stage.sv
rtl/inst_decoder.sv
rtl/execute_stage.sv
rtl/cpu_top.sv
tb/tb_clock.sv
tb/spi_ram_model.sv
tb/tb_cpu.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_cpu
FLIST     = flist.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "=== PASS ==="

clean:
	rm -rf $(OBJ_DIR)
